//--- run_sim.sh
#!/usr/bin/env bash
# build and run the led panel testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --top-module led_panel_tb \
    -f sources.f \
    -o Vled_panel_tb

# the simulation log decides the result
./obj_dir/Vled_panel_tb 2>&1 | tee sim.log || true

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"
exit 0

//--- sources.f
verilog/led_panel_pkg.sv
verilog/timeout.sv
verilog/framebuffer_ram.sv
verilog/apb_framebuffer_port.sv
verilog/framebuffer_fetch.sv
verilog/panel_scan_control.sv
verilog/led_panel_top.sv
testbench/led_panel_tb.sv

//--- testbench/led_panel_tb.sv
`timescale 1ns/10ps

module led_panel_tb
    import led_panel_pkg::*;
;

    localparam int words = pixel_width_default * pixel_halfheight_default;
    // one row is 64 columns of 6 cycles plus blank, latch and unblank
    localparam int row_cycles = pixel_width_default * 6 + 3;
    localparam int frame_cycles = pixel_halfheight_default * row_cycles;
    localparam int write_cycles = 2 * words;
    localparam int cycle_limit = write_cycles + 2 * frame_cycles + 4000;

    logic clk_in;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic panel_r0;
    logic panel_g0;
    logic panel_b0;
    logic panel_r1;
    logic panel_g1;
    logic panel_b1;
    logic panel_clk;
    logic panel_latch;
    logic panel_oe_n;
    logic [3:0] panel_row;

    // copy of every word written over apb
    logic [ram_data_bits-1:0] shadow [words];

    int error_count = 0;
    int cycle_count = 0;
    bit enable_sent = 0;

    // pin checker state
    logic clk_prev;
    logic [3:0] prev_row;
    logic [3:0] cur_row;
    int k;
    int wraps;
    int pixels_checked;
    bit live_seen;
    logic [9:0] live_index;

    led_panel_top dut (
        .clk_in(clk_in), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .panel_r0(panel_r0), .panel_g0(panel_g0), .panel_b0(panel_b0),
        .panel_r1(panel_r1), .panel_g1(panel_g1), .panel_b1(panel_b1),
        .panel_clk(panel_clk), .panel_latch(panel_latch), .panel_oe_n(panel_oe_n),
        .panel_row(panel_row)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic fail_now(input string what);
        error_count++;
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // k-th pixel shifted in a row comes from the mirrored column
    function automatic logic [ram_data_bits-1:0] expected_pixels(input logic [3:0] row,
                                                                 input int pos);
        logic [5:0] col;
        col = 6'(pixel_width_default - 1 - pos);
        return shadow[{row, col}];
    endfunction

    task automatic compare_pin(input string name, input logic got, input logic want);
        assert (got === want) else
            fail_now($sformatf("[FAIL] %s = %h, expected %h (row %0d, pixel %0d)",
                               name, got, want, cur_row, k));
    endtask

    // setup then access, next transfer may follow straight away
    task automatic apb_write(input logic [12:0] addr, input logic [31:0] data);
        @(posedge clk_in);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk_in);
        penable <= 1'b1;
        @(negedge clk_in);
        assert (pready) else fail_now("pready was low in the access phase of a write");
        assert (!pslverr) else
            fail_now($sformatf("[FAIL] pslverr = %h, expected %h (write to %h)",
                               pslverr, 1'b0, addr));
    endtask

    task automatic apb_read(input logic [12:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_in);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        pwdata <= '0;
        @(posedge clk_in);
        penable <= 1'b1;
        @(negedge clk_in);
        assert (pready) else fail_now("pready was low in the access phase of a read");
        data = prdata;
        err = pslverr;
    endtask

    task automatic bus_idle();
        @(posedge clk_in);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            fail_now("timeout, two frames were not seen at the panel pins in time");
        end
    end

    // pin checker, sampled mid-cycle where the combinational pins are settled
    always @(negedge clk_in) begin
        logic [ram_data_bits-1:0] exp;
        if (reset) begin
            clk_prev = 1'b0;
            prev_row = 4'd0;
            cur_row = 4'd0;
            k = 0;
            wraps = 0;
            pixels_checked = 0;
        end else begin
            if (panel_clk && !clk_prev) begin
                assert (enable_sent) else fail_now("panel_clk toggled before scan enable");
                assert (k < pixel_width_default) else
                    fail_now("more than 64 shift clocks in one row");
                assert (panel_row == cur_row) else
                    fail_now($sformatf("[FAIL] panel_row = %h, expected %h",
                                       panel_row, cur_row));
                exp = expected_pixels(cur_row, k);
                compare_pin("panel_r0", panel_r0, exp[0]);
                compare_pin("panel_g0", panel_g0, exp[1]);
                compare_pin("panel_b0", panel_b0, exp[2]);
                compare_pin("panel_r1", panel_r1, exp[3]);
                compare_pin("panel_g1", panel_g1, exp[4]);
                compare_pin("panel_b1", panel_b1, exp[5]);
                // the rewritten word, seen again in the second frame
                if (wraps == 1 && {cur_row, 6'(pixel_width_default - 1 - k)} == live_index) begin
                    live_seen = 1'b1;
                end
                k++;
                pixels_checked++;
            end
            if (panel_latch) begin
                assert (panel_oe_n) else
                    fail_now($sformatf("[FAIL] panel_oe_n = %h, expected %h at latch",
                                       panel_oe_n, 1'b1));
                assert (k == pixel_width_default) else
                    fail_now($sformatf("[FAIL] shift count = %h, expected %h at latch",
                                       k, pixel_width_default));
                k = 0;
                cur_row = 4'(cur_row + 4'd1);
            end
            // row address only ever steps by one, 15 wraps to 0
            if (panel_row != prev_row) begin
                assert (panel_row == 4'(prev_row + 4'd1)) else
                    fail_now($sformatf("[FAIL] panel_row = %h, expected %h",
                                       panel_row, 4'(prev_row + 4'd1)));
                if (prev_row == 4'd15) begin
                    wraps++;
                end
            end
            prev_row = panel_row;
            clk_prev = panel_clk;
        end
    end

    initial begin
        logic [31:0] seed;
        logic [31:0] rdata;
        logic err;
        logic [ram_data_bits-1:0] data;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        live_seen = 1'b0;
        live_index = {4'd1, 6'd10};
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;

        @(negedge clk_in);
        assert (panel_oe_n && !panel_clk && !panel_latch) else
            fail_now($sformatf("[FAIL] oe_n/clk/latch = %h/%h/%h, expected 1/0/0",
                               panel_oe_n, panel_clk, panel_latch));

        // fill the framebuffer with pseudo random pixel pairs
        seed = 32'd20651;
        for (int i = 0; i < words; i++) begin
            seed = lcg_next(seed);
            data = seed[21:16];
            shadow[i] = data;
            apb_write(13'(i * 4), {26'b0, data});
        end
        bus_idle();
        // panel must stay quiet without enable
        repeat (20) @(posedge clk_in);

        enable_sent = 1'b1;
        apb_write(ctrl_addr, 32'd1);
        apb_read(ctrl_addr, rdata, err);
        assert (rdata == 32'd1 && !err) else
            fail_now($sformatf("[FAIL] ctrl prdata = %h, expected %h", rdata, 32'd1));
        apb_read(13'h0010, rdata, err);
        assert (err && rdata == 32'd0) else
            fail_now($sformatf("[FAIL] pslverr = %h, expected %h (framebuffer read)",
                               err, 1'b1));
        apb_read(13'h1008, rdata, err);
        assert (err && rdata == 32'd0) else
            fail_now($sformatf("[FAIL] pslverr/prdata = %h/%h, expected %h/%h (unmapped read)",
                               err, rdata, 1'b1, 32'd0));
        bus_idle();

        // rewrite a word in row 1 once the scan has moved past it
        while (wraps != 0 || cur_row < 4'd3) begin
            @(posedge clk_in);
        end
        data = shadow[live_index] ^ 6'h3f;
        shadow[live_index] = data;
        apb_write({1'b0, live_index, 2'b00}, {26'b0, data});
        bus_idle();

        while (wraps < 2) begin
            @(posedge clk_in);
        end
        apb_read(status_addr, rdata, err);
        assert (rdata == 32'd2 && !err) else
            fail_now($sformatf("[FAIL] status prdata = %h, expected %h", rdata, 32'd2));
        bus_idle();

        assert (pixels_checked >= 2 * words) else
            fail_now("fewer pixels were shifted than two full frames hold");
        assert (live_seen) else fail_now("the rewritten word was never shifted out");

        if (error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_now("checks failed during the run");
        end
    end

endmodule

//--- verilog/apb_framebuffer_port.sv
`timescale 1ns/10ps

module apb_framebuffer_port
    import led_panel_pkg::*;
(
    input logic reset,
    input logic clk_in,

    // apb slave
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [12:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,

    // status from the scan side
    input logic [15:0] frame_count,
    output logic scan_enable,

    // framebuffer write port
    output logic wr_en,
    output logic [fb_addr_bits-1:0] wr_addr,
    output logic [ram_data_bits-1:0] wr_data
);

    logic access;
    logic fb_hit;
    logic ctrl_hit;
    logic status_hit;
    logic bad_access;

    // access phase of a transfer
    assign access = psel && penable;

    // address decode
    assign fb_hit = (paddr < ctrl_addr);
    assign ctrl_hit = (paddr == ctrl_addr);
    assign status_hit = (paddr == status_addr);

    // framebuffer is write only, status is read only
    // anything else outside the map is refused too
    assign bad_access = (fb_hit && !pwrite)
                      || (status_hit && pwrite)
                      || !(fb_hit || ctrl_hit || status_hit);

    // no wait states
    assign pready = 1'b1;
    assign pslverr = access && bad_access;

    // framebuffer write strobe, word index from paddr[11:2]
    assign wr_en = access && pwrite && fb_hit;
    assign wr_addr = paddr[fb_addr_bits+1:2];
    assign wr_data = pwdata[ram_data_bits-1:0];

    // read mux, zero on error or idle
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (ctrl_hit) begin
                prdata = {31'b0, scan_enable};
            end else if (status_hit) begin
                prdata = {16'b0, frame_count};
            end
        end
    end

    // control register, bit 0 enables scanning
    always_ff @(posedge clk_in) begin
        if (reset) begin
            scan_enable <= 1'b0;
        end else if (access && pwrite && ctrl_hit) begin
            scan_enable <= pwdata[0];
        end
    end

    // access phase always follows a selected setup phase
    access_after_setup: assert property (
        @(posedge clk_in) disable iff (reset)
        penable |-> psel && $past(psel)
    );

endmodule

//--- verilog/framebuffer_fetch.sv
`timescale 1ns/10ps

module framebuffer_fetch
    import led_panel_pkg::*;
#(
    parameter int PIXEL_WIDTH = pixel_width_default,
    parameter int PIXEL_HALFHEIGHT = pixel_halfheight_default,
    parameter int LOAD_CYCLES = 3
) (
    input logic reset,
    input logic clk_in,

    // pixel position from the scan controller
    input logic [$clog2(PIXEL_WIDTH)-1:0] column_address,
    input logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address,
    input logic pixel_load_start,

    // framebuffer read port
    input logic [ram_data_bits-1:0] ram_data_in,
    output logic [$clog2(PIXEL_HALFHEIGHT)+$clog2(PIXEL_WIDTH)-1:0] ram_address,
    output logic ram_clk_enable,

    // captured pixel pair
    output logic [bits_per_subpanel-1:0] pixeldata_top,
    output logic [bits_per_subpanel-1:0] pixeldata_bottom
);

    localparam int counter_bits = $clog2(LOAD_CYCLES + 1);

    logic [counter_bits-1:0] load_counter;

    // column is reversed, first pixel shifted ends up at the far edge
    assign ram_address = {row_address, ~column_address};

    // times the read, ram is enabled while the count runs
    timeout #(
        .COUNTER_WIDTH(counter_bits)
    ) timeout_pixel_load (
        .reset(reset),
        .clk_in(clk_in),
        .start(pixel_load_start),
        .value(counter_bits'(LOAD_CYCLES)),
        .counter(load_counter),
        .running(ram_clk_enable)
    );

    // count LOAD_CYCLES: address presented, ram enabled
    // count 2: registered ram output valid
    // count 1: grab both halves
    always_ff @(posedge clk_in) begin
        if (load_counter == counter_bits'(1)) begin
            {pixeldata_bottom, pixeldata_top} <= ram_data_in;
        end
    end

endmodule

//--- verilog/framebuffer_ram.sv
`timescale 1ns/10ps

module framebuffer_ram #(
    parameter int ADDR_BITS = 10,
    parameter int DATA_BITS = 6
) (
    input logic clk_in,

    // write port, driven from apb
    input logic wr_en,
    input logic [ADDR_BITS-1:0] wr_addr,
    input logic [DATA_BITS-1:0] wr_data,

    // read port, driven from the fetch block
    input logic rd_en,
    input logic [ADDR_BITS-1:0] rd_addr,
    output logic [DATA_BITS-1:0] rd_data
);

    localparam int depth = 1 << ADDR_BITS;

    logic [DATA_BITS-1:0] mem [depth];

    // synchronous write
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle latency
    // output holds its last value while rd_en is low
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- verilog/led_panel_pkg.sv
package led_panel_pkg;

    // panel geometry
    // two 16-row halves are shifted together, so one row address serves both
    localparam int pixel_width_default = 64;
    localparam int pixel_halfheight_default = 16;

    // 1-bit rgb for a single pixel, {b,g,r}
    localparam int bits_per_subpanel = 3;

    // one framebuffer word holds a pixel pair
    // top pixel in the low bits, bottom pixel in the high bits
    localparam int ram_data_bits = 2 * bits_per_subpanel;

    // framebuffer word index is {row, column}
    localparam int fb_addr_bits =
        $clog2(pixel_width_default) + $clog2(pixel_halfheight_default);

    // apb address map
    // everything below ctrl_addr is framebuffer, one word per 4 bytes
    localparam logic [12:0] ctrl_addr = 13'h1000;
    localparam logic [12:0] status_addr = 13'h1004;

    // scan sequencer states
    typedef enum logic [2:0] {
        s_idle,
        s_load,
        s_wait,
        s_shift_hi,
        s_shift_lo,
        s_blank,
        s_latch,
        s_unblank
    } scan_state_t;

endpackage

//--- verilog/led_panel_top.sv
`timescale 1ns/10ps

module led_panel_top
    import led_panel_pkg::*;
#(
    parameter int PIXEL_WIDTH = pixel_width_default,
    parameter int PIXEL_HALFHEIGHT = pixel_halfheight_default,
    parameter int LOAD_CYCLES = 3
) (
    input logic clk_in,
    input logic reset,

    // apb slave
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [12:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,

    // hub75 pins
    output logic panel_r0,
    output logic panel_g0,
    output logic panel_b0,
    output logic panel_r1,
    output logic panel_g1,
    output logic panel_b1,
    output logic panel_clk,
    output logic panel_latch,
    output logic panel_oe_n,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] panel_row
);

    localparam int col_bits = $clog2(PIXEL_WIDTH);
    localparam int row_bits = $clog2(PIXEL_HALFHEIGHT);
    localparam int addr_bits = row_bits + col_bits;

    logic scan_enable;
    logic [15:0] frame_count;

    // apb to ram
    logic wr_en;
    logic [addr_bits-1:0] wr_addr;
    logic [ram_data_bits-1:0] wr_data;

    // fetch to ram
    logic [addr_bits-1:0] ram_address;
    logic ram_clk_enable;
    logic [ram_data_bits-1:0] ram_data;

    // scan to fetch and back
    logic [col_bits-1:0] column_address;
    logic [row_bits-1:0] row_address;
    logic pixel_load_start;
    logic [bits_per_subpanel-1:0] pixeldata_top;
    logic [bits_per_subpanel-1:0] pixeldata_bottom;

    apb_framebuffer_port u_apb (
        .reset(reset),
        .clk_in(clk_in),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .frame_count(frame_count),
        .scan_enable(scan_enable),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    framebuffer_ram #(
        .ADDR_BITS(addr_bits),
        .DATA_BITS(ram_data_bits)
    ) u_ram (
        .clk_in(clk_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en(ram_clk_enable),
        .rd_addr(ram_address),
        .rd_data(ram_data)
    );

    framebuffer_fetch #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .LOAD_CYCLES(LOAD_CYCLES)
    ) u_fetch (
        .reset(reset),
        .clk_in(clk_in),
        .column_address(column_address),
        .row_address(row_address),
        .pixel_load_start(pixel_load_start),
        .ram_data_in(ram_data),
        .ram_address(ram_address),
        .ram_clk_enable(ram_clk_enable),
        .pixeldata_top(pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom)
    );

    panel_scan_control #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)
    ) u_scan (
        .reset(reset),
        .clk_in(clk_in),
        .scan_enable(scan_enable),
        .pixeldata_top(pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom),
        .column_address(column_address),
        .row_address(row_address),
        .pixel_load_start(pixel_load_start),
        .panel_r0(panel_r0),
        .panel_g0(panel_g0),
        .panel_b0(panel_b0),
        .panel_r1(panel_r1),
        .panel_g1(panel_g1),
        .panel_b1(panel_b1),
        .panel_clk(panel_clk),
        .panel_latch(panel_latch),
        .panel_oe_n(panel_oe_n),
        .panel_row(panel_row),
        .frame_count(frame_count)
    );

endmodule

//--- verilog/panel_scan_control.sv
`timescale 1ns/10ps

module panel_scan_control
    import led_panel_pkg::*;
#(
    parameter int PIXEL_WIDTH = pixel_width_default,
    parameter int PIXEL_HALFHEIGHT = pixel_halfheight_default
) (
    input logic reset,
    input logic clk_in,
    input logic scan_enable,

    // pixel pair from the fetch block
    input logic [bits_per_subpanel-1:0] pixeldata_top,
    input logic [bits_per_subpanel-1:0] pixeldata_bottom,

    // fetch requests
    output logic [$clog2(PIXEL_WIDTH)-1:0] column_address,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address,
    output logic pixel_load_start,

    // panel pins
    output logic panel_r0,
    output logic panel_g0,
    output logic panel_b0,
    output logic panel_r1,
    output logic panel_g1,
    output logic panel_b1,
    output logic panel_clk,
    output logic panel_latch,
    output logic panel_oe_n,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] panel_row,

    output logic [15:0] frame_count
);

    localparam int col_bits = $clog2(PIXEL_WIDTH);
    localparam int row_bits = $clog2(PIXEL_HALFHEIGHT);
    // cycles spent waiting on the fetch, matches its load time
    localparam int wait_cycles = 3;

    localparam logic [col_bits-1:0] last_col = col_bits'(PIXEL_WIDTH - 1);
    localparam logic [row_bits-1:0] last_row = row_bits'(PIXEL_HALFHEIGHT - 1);

    scan_state_t state;
    logic [col_bits-1:0] col;
    logic [row_bits-1:0] row;
    logic [1:0] wait_count;
    logic shifting;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= s_idle;
            col <= '0;
            row <= '0;
            wait_count <= '0;
            frame_count <= '0;
        end else begin
            case (state)
                s_idle: begin
                    // only start at the top of a frame
                    if (scan_enable) begin
                        state <= s_load;
                    end
                end
                s_load: begin
                    wait_count <= 2'(wait_cycles - 1);
                    state <= s_wait;
                end
                s_wait: begin
                    // data lands in the fetch block on the last wait cycle
                    if (wait_count == '0) begin
                        state <= s_shift_hi;
                    end else begin
                        wait_count <= wait_count - 1'b1;
                    end
                end
                s_shift_hi: begin
                    state <= s_shift_lo;
                end
                s_shift_lo: begin
                    if (col == last_col) begin
                        col <= '0;
                        state <= s_blank;
                    end else begin
                        col <= col + 1'b1;
                        state <= s_load;
                    end
                end
                s_blank: begin
                    state <= s_latch;
                end
                s_latch: begin
                    state <= s_unblank;
                end
                s_unblank: begin
                    row <= row + 1'b1;
                    if (row == last_row) begin
                        // frame done, stop here if scanning was turned off
                        frame_count <= frame_count + 1'b1;
                        state <= scan_enable ? s_load : s_idle;
                    end else begin
                        state <= s_load;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // fetch interface
    assign column_address = col;
    assign row_address = row;
    assign pixel_load_start = (state == s_load);

    // rgb held across both shift cycles so it is stable at the clock edge
    assign shifting = (state == s_shift_hi) || (state == s_shift_lo);
    assign {panel_b0, panel_g0, panel_r0} = shifting ? pixeldata_top : '0;
    assign {panel_b1, panel_g1, panel_r1} = shifting ? pixeldata_bottom : '0;

    assign panel_clk = (state == s_shift_hi);
    assign panel_latch = (state == s_latch);
    // dark while idle and around the latch
    assign panel_oe_n = (state == s_idle) || (state == s_blank) || (state == s_latch);
    assign panel_row = row;

    // fetched pair must hold through the whole shift
    // a fetch slower than the wait would change it under the clock
    pixels_stable_while_shifting: assert property (
        @(posedge clk_in) disable iff (reset)
        panel_clk |=> $stable({pixeldata_top, pixeldata_bottom})
    );

endmodule

//--- verilog/timeout.sv
`timescale 1ns/10ps

module timeout #(
    parameter int COUNTER_WIDTH = 2
) (
    input logic reset,
    input logic clk_in,
    input logic start,
    input logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic running
);

    // loadable down-counter, parks at zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // load takes effect on the edge after start
            counter <= value;
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

    // busy for as long as the count is non-zero
    assign running = (counter != '0);

    // the caller must leave enough cycles between loads
    // a restart mid-count would cut the ram read short
    start_while_idle: assert property (
        @(posedge clk_in) disable iff (reset)
        start |-> !running
    );

endmodule
